// File: hw/tiny_pkg.sv
/*
 * Shared types and constants for the accumulator core and its memory.
 * Holds the opcode and FSM state enums, the instruction layout, the
 * request/grant/rvalid bus structs and the address map.
 */
`default_nettype none

package tiny_pkg;

    // opcodes outside this list decode as a NOP in the core
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ADDI  = 4'h1,
        OP_XORI  = 4'h2,
        OP_SHLI  = 4'h3,
        OP_LOAD  = 4'h4,
        OP_STORE = 4'h5
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_INSTR,
        EXECUTE,
        WAIT_DATA,
        DONE
    } core_state_e;

    // imm_addr is the immediate for arithmetic ops and the byte address for memory ops
    typedef struct packed {
        logic [3:0]  opcode;
        logic [7:0]  rsvd;
        logic [19:0] imm_addr;
    } instr_t;

    // the instruction request carries only the byte address of the fetch
    typedef logic [19:0] instr_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } instr_rsp_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } data_rsp_t;

    localparam logic [31:0] EXIT_ADDR  = 32'h0008_0000;
    localparam int unsigned WORD_BYTES = 4;

endpackage

`default_nettype wire

// File: hw/dp_ram.sv
/*
 * Word-organized dual-port RAM behind mm_ram.
 * One read-only port serves instruction fetches, the other serves data
 * reads and writes. Addresses are byte addresses and both reads are registered.
 */
`timescale 1ns/1ps
`default_nettype none

module dp_ram import tiny_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic                      clk_i,

    input  logic                      instr_en_i,
    input  logic [RAM_ADDR_WIDTH-1:0] instr_addr_i,
    output logic [31:0]               instr_rdata_o,

    input  logic                      data_en_i,
    input  logic                      data_we_i,
    input  logic [RAM_ADDR_WIDTH-1:0] data_addr_i,
    input  logic [31:0]               data_wdata_i,
    output logic [31:0]               data_rdata_o
);

    localparam int unsigned NUM_WORDS = (2 ** RAM_ADDR_WIDTH) / WORD_BYTES;

    // the testbench preloads programs and data straight into this array
    logic [31:0] mem [NUM_WORDS];

    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            instr_rdata_o <= mem[instr_addr_i / WORD_BYTES];
        end
    end

    // a write in the same cycle still returns the previous word on the read port
    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            if (data_we_i) begin
                mem[data_addr_i / WORD_BYTES] <= data_wdata_i;
            end
            data_rdata_o <= mem[data_addr_i / WORD_BYTES];
        end
    end

endmodule

`default_nettype wire

// File: hw/mm_ram.sv
/*
 * Memory front end for the core with the RAM and the exit register.
 * Both ports are granted as soon as they request, and rvalid follows one
 * cycle later. A data write to EXIT_ADDR ends the program and sets the
 * pass/fail outputs from the written value.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_ram import tiny_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        instr_req_i,
    input  instr_req_t  instr_addr_i,
    output instr_rsp_t  instr_rsp_o,

    input  logic        data_req_i,
    input  data_req_t   data_req_o_bus_i,
    output data_rsp_t   data_rsp_o,

    output logic        exit_valid_o,
    output logic [31:0] exit_value_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o
);

    logic        instr_is_exit;
    logic        instr_pending_q;
    logic        instr_exit_q;
    logic [31:0] ram_instr_rdata;

    logic        data_in_ram;
    logic        data_is_exit;
    logic        exit_write;
    logic        data_pending_q;
    logic        data_exit_q;
    logic [31:0] ram_data_rdata;

    // only addresses below 2**RAM_ADDR_WIDTH are backed by the RAM
    assign data_in_ram   = (data_req_o_bus_i.addr >> RAM_ADDR_WIDTH) == '0;
    assign data_is_exit  = data_req_o_bus_i.addr == EXIT_ADDR;
    assign exit_write    = data_req_i && data_req_o_bus_i.we && data_is_exit;
    assign instr_is_exit = instr_addr_i == instr_req_t'(EXIT_ADDR);

    dp_ram #(
        .RAM_ADDR_WIDTH ( RAM_ADDR_WIDTH )
    ) mem_i (
        .clk_i          ( clk_i                                       ),
        .instr_en_i     ( instr_req_i                                 ),
        .instr_addr_i   ( instr_addr_i[RAM_ADDR_WIDTH-1:0]            ),
        .instr_rdata_o  ( ram_instr_rdata                             ),
        .data_en_i      ( data_req_i && data_in_ram                   ),
        .data_we_i      ( data_req_o_bus_i.we                         ),
        .data_addr_i    ( data_req_o_bus_i.addr[RAM_ADDR_WIDTH-1:0]   ),
        .data_wdata_i   ( data_req_o_bus_i.wdata                      ),
        .data_rdata_o   ( ram_data_rdata                              )
    );

    // pending flags turn every grant into an rvalid on the following cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_pending_q <= 1'b0;
            instr_exit_q    <= 1'b0;
            data_pending_q  <= 1'b0;
            data_exit_q     <= 1'b0;
        end else begin
            instr_pending_q <= instr_req_i;
            instr_exit_q    <= instr_req_i && instr_is_exit;
            data_pending_q  <= data_req_i;
            data_exit_q     <= data_req_i && data_is_exit;
        end
    end

    always_comb begin
        instr_rsp_o.gnt    = instr_req_i;
        instr_rsp_o.rvalid = instr_pending_q;
        instr_rsp_o.rdata  = instr_exit_q ? '0 : ram_instr_rdata;

        data_rsp_o.gnt     = data_req_i;
        data_rsp_o.rvalid  = data_pending_q;
        data_rsp_o.rdata   = data_exit_q ? '0 : ram_data_rdata;
    end

    // exit register, once written it stays valid until the next reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else if (exit_write) begin
            exit_valid_o   <= 1'b1;
            exit_value_o   <= data_req_o_bus_i.wdata;
            tests_passed_o <= data_req_o_bus_i.wdata == '0;
            tests_failed_o <= data_req_o_bus_i.wdata != '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/tiny_core.sv
/*
 * Minimal accumulator core with separate instruction and data buses.
 * Each instruction is fetched, then executed against the 32-bit
 * accumulator. Loads and stores go out on the data bus, and a store to
 * EXIT_ADDR halts the core until reset.
 */
`timescale 1ns/1ps
`default_nettype none

module tiny_core import tiny_pkg::*; #(
    parameter instr_req_t BOOT_ADDR = '0
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       fetch_enable_i,

    output logic       instr_req_o,
    output instr_req_t instr_addr_o,
    input  instr_rsp_t instr_rsp_i,

    output logic       data_req_o,
    output data_req_t  data_bus_o,
    input  data_rsp_t  data_rsp_i
);

    core_state_e state_q;
    core_state_e state_d;

    instr_req_t  pc_q;
    instr_t      ir_q;
    logic [31:0] acc_q;
    logic        data_req_q;

    opcode_e     op;
    logic [31:0] imm_sext;
    logic        is_mem_op;
    logic        is_exit_store;

    assign op       = opcode_e'(ir_q.opcode);
    assign imm_sext = {{12{ir_q.imm_addr[19]}}, ir_q.imm_addr};

    assign is_mem_op     = (op == OP_LOAD) || (op == OP_STORE);
    assign is_exit_store = (op == OP_STORE) && (data_bus_o.addr == EXIT_ADDR);

    // the fetch request is held in FETCH until it is granted
    assign instr_req_o  = state_q == FETCH;
    assign instr_addr_o = pc_q;

    // the data request comes from a flop so it starts on the cycle after EXECUTE
    assign data_req_o       = data_req_q;
    assign data_bus_o.addr  = {12'h000, ir_q.imm_addr};
    assign data_bus_o.we    = op == OP_STORE;
    assign data_bus_o.wdata = acc_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (fetch_enable_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (instr_rsp_i.gnt) begin
                    state_d = WAIT_INSTR;
                end
            end
            WAIT_INSTR: begin
                if (instr_rsp_i.rvalid) begin
                    state_d = EXECUTE;
                end
            end
            EXECUTE: begin
                state_d = is_mem_op ? WAIT_DATA : FETCH;
            end
            WAIT_DATA: begin
                // rvalid never arrives while the request is still outstanding
                if (data_rsp_i.rvalid) begin
                    state_d = is_exit_store ? DONE : FETCH;
                end
            end
            DONE: begin
                state_d = DONE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= BOOT_ADDR;
        end else if (instr_req_o && instr_rsp_i.gnt) begin
            pc_q <= pc_q + instr_req_t'(WORD_BYTES);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == WAIT_INSTR && instr_rsp_i.rvalid) begin
            ir_q <= instr_t'(instr_rsp_i.rdata);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_req_q <= 1'b0;
        end else if (state_q == EXECUTE && is_mem_op) begin
            data_req_q <= 1'b1;
        end else if (data_req_q && data_rsp_i.gnt) begin
            data_req_q <= 1'b0;
        end
    end

    // XORI uses the same sign-extended immediate as ADDI
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else if (state_q == EXECUTE) begin
            unique case (op)
                OP_ADDI: acc_q <= acc_q + imm_sext;
                OP_XORI: acc_q <= acc_q ^ imm_sext;
                OP_SHLI: acc_q <= acc_q << ir_q.imm_addr[4:0];
                default: acc_q <= acc_q;
            endcase
        end else if (state_q == WAIT_DATA && data_rsp_i.rvalid && op == OP_LOAD) begin
            acc_q <= data_rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/core_wrapper.sv
/*
 * Top level of the harness with tiny_core and mm_ram.
 * The testbench drives fetch_enable_i and watches the exit outputs.
 * Programs are placed in ram_i.mem_i.mem before the core is started.
 */
`timescale 1ns/1ps
`default_nettype none

module core_wrapper import tiny_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = 16,
    parameter instr_req_t  BOOT_ADDR      = 'h0
) (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        fetch_enable_i,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic [31:0] exit_value_o,
    output logic        exit_valid_o
);

    // instruction and data buses between the core and the memory
    logic       instr_req;
    instr_req_t instr_addr;
    instr_rsp_t instr_rsp;

    logic       data_req;
    data_req_t  data_bus;
    data_rsp_t  data_rsp;

    tiny_core #(
        .BOOT_ADDR        ( BOOT_ADDR      )
    ) core_i (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .fetch_enable_i   ( fetch_enable_i ),
        .instr_req_o      ( instr_req      ),
        .instr_addr_o     ( instr_addr     ),
        .instr_rsp_i      ( instr_rsp      ),
        .data_req_o       ( data_req       ),
        .data_bus_o       ( data_bus       ),
        .data_rsp_i       ( data_rsp       )
    );

    // RAM plus the memory mapped exit register
    mm_ram #(
        .RAM_ADDR_WIDTH   ( RAM_ADDR_WIDTH )
    ) ram_i (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .instr_req_i      ( instr_req      ),
        .instr_addr_i     ( instr_addr     ),
        .instr_rsp_o      ( instr_rsp      ),
        .data_req_i       ( data_req       ),
        .data_req_o_bus_i ( data_bus       ),
        .data_rsp_o       ( data_rsp       ),
        .exit_valid_o     ( exit_valid_o   ),
        .exit_value_o     ( exit_value_o   ),
        .tests_passed_o   ( tests_passed_o ),
        .tests_failed_o   ( tests_failed_o )
    );

endmodule

`default_nettype wire

// File: test/core_wrapper_chk.sv
/*
 * Bus protocol and exit register assertions, bound into core_wrapper.
 * Failures are counted in assert_failures for the testbench to read.
 */
`timescale 1ns/1ps
`default_nettype none

module core_wrapper_chk import tiny_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       instr_req_i,
    input  instr_rsp_t instr_rsp_i,
    input  logic       data_req_i,
    input  data_rsp_t  data_rsp_i,
    input  logic       exit_valid_i,
    input  logic       tests_passed_i,
    input  logic       tests_failed_i
);

    int unsigned assert_failures = 0;

    // every grant gets its response exactly one cycle later
    instr_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rsp_i.gnt |=> instr_rsp_i.rvalid)
        else begin
            $error("instruction grant not followed by rvalid");
            assert_failures++;
        end

    data_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rsp_i.gnt |=> data_rsp_i.rvalid)
        else begin
            $error("data grant not followed by rvalid");
            assert_failures++;
        end

    instr_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rsp_i.gnt |-> instr_req_i)
        else begin
            $error("instruction grant without a request");
            assert_failures++;
        end

    data_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rsp_i.gnt |-> data_req_i)
        else begin
            $error("data grant without a request");
            assert_failures++;
        end

    pass_fail_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(tests_passed_i && tests_failed_i))
        else begin
            $error("pass and fail outputs high together");
            assert_failures++;
        end

    result_needs_exit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tests_passed_i || tests_failed_i) |-> exit_valid_i)
        else begin
            $error("pass or fail output high without exit_valid");
            assert_failures++;
        end

endmodule

bind core_wrapper core_wrapper_chk chk_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .instr_req_i    ( instr_req      ),
    .instr_rsp_i    ( instr_rsp      ),
    .data_req_i     ( data_req       ),
    .data_rsp_i     ( data_rsp       ),
    .exit_valid_i   ( exit_valid_o   ),
    .tests_passed_i ( tests_passed_o ),
    .tests_failed_i ( tests_failed_o )
);

`default_nettype wire

// File: test/tb_core_wrapper.sv
/*
 * Self-checking testbench for core_wrapper.
 * Builds random straight-line programs, preloads them into the RAM while
 * reset is held, runs them on the core and compares the exit outputs with
 * an accumulator model that keeps its own copy of the data words.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core_wrapper import tiny_pkg::*; ();

    localparam int unsigned CLK_PERIOD = 20;
    localparam int unsigned RAM_AW     = 16;
    localparam instr_req_t  BOOT       = 20'h00100;
    localparam logic [19:0] DATA_BASE  = 20'h04000;
    localparam int unsigned DATA_WORDS = 16;
    localparam int unsigned MIN_BODY   = 8;
    localparam int unsigned MAX_BODY   = 24;
    // body plus the forced-zero tail and the exit store
    localparam int unsigned MAX_PROG   = MAX_BODY + 4;
    localparam int unsigned EXIT_LIMIT = MAX_PROG * 8;
    localparam int unsigned MAX_IDLE   = 40;
    localparam int unsigned NUM_RANDOM = 12;
    // random runs, the delayed start, the interrupted run and the run after it
    localparam int unsigned NUM_RUNS   = NUM_RANDOM + 3;
    // every run may use the full exit limit and the delayed start idles on top of that
    localparam int unsigned WATCHDOG_NS =
        (NUM_RUNS * (EXIT_LIMIT + 8) + EXIT_LIMIT + MAX_IDLE + 500) * CLK_PERIOD;

    localparam int MODE_ARITH = 0;
    localparam int MODE_MIXED = 1;
    localparam int MODE_ZERO  = 2;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        fetch_enable;
    logic        tests_passed;
    logic        tests_failed;
    logic [31:0] exit_value;
    logic        exit_valid;

    logic [31:0] model_acc;
    logic [31:0] model_mem [DATA_WORDS];
    logic [31:0] expected_exit;
    logic [31:0] prog [$];

    core_wrapper #(
        .RAM_ADDR_WIDTH ( RAM_AW       ),
        .BOOT_ADDR      ( BOOT         )
    ) dut_i (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_value_o   ( exit_value   ),
        .exit_valid_o   ( exit_valid   )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all programs finished", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog timeout");
    end

    // a failed bus or exit assertion ends the run at once
    initial begin
        wait (dut_i.chk_i.assert_failures != 0);
        $display("a bus or exit assertion failed at time %0t", $time);
        $display("Some tests failed");
        $fatal(1, "assertion failure");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // model of the accumulator semantics where the exit store records the value
    task automatic exec_model(input logic [31:0] word);
        logic [3:0]  opc;
        logic [19:0] field;
        logic [31:0] imm;
        int unsigned idx;
        opc   = word[31:28];
        field = word[19:0];
        imm   = {{12{field[19]}}, field};
        idx   = (field - DATA_BASE) / WORD_BYTES;
        case (opc)
            OP_ADDI: model_acc = model_acc + imm;
            OP_XORI: model_acc = model_acc ^ imm;
            OP_SHLI: model_acc = model_acc << field[4:0];
            OP_LOAD: model_acc = model_mem[idx];
            OP_STORE: begin
                if ({12'h000, field} == EXIT_ADDR) begin
                    expected_exit = model_acc;
                end else begin
                    model_mem[idx] = model_acc;
                end
            end
            default: ;
        endcase
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
        exec_model(word);
    endtask

    function automatic logic [31:0] random_word(input int mode);
        logic [3:0]  opc;
        logic [19:0] field;
        int unsigned pick;
        pick = $urandom_range((mode == MODE_ARITH) ? 4 : 6, 0);
        case (pick)
            0: opc = OP_NOP;
            1: opc = OP_ADDI;
            2: opc = OP_XORI;
            3: opc = OP_SHLI;
            // an undefined opcode that must behave like a NOP
            4: opc = 4'hc;
            5: opc = OP_LOAD;
            default: opc = OP_STORE;
        endcase
        if (opc == OP_LOAD || opc == OP_STORE) begin
            field = DATA_BASE + 20'($urandom_range(DATA_WORDS - 1, 0) * WORD_BYTES);
        end else begin
            field = 20'($urandom());
        end
        return {opc, 8'($urandom()), field};
    endfunction

    // fills the data window and the program area of the RAM and runs the model
    task automatic build_program(input int mode);
        int unsigned body_len;
        model_acc     = '0;
        expected_exit = '0;
        prog.delete();
        for (int k = 0; k < DATA_WORDS; k++) begin
            model_mem[k] = $urandom();
            dut_i.ram_i.mem_i.mem[(DATA_BASE / WORD_BYTES) + k] = model_mem[k];
        end
        body_len = $urandom_range(MAX_BODY, MIN_BODY);
        for (int i = 0; i < body_len; i++) begin
            emit(random_word((mode == MODE_ARITH) ? MODE_ARITH : MODE_MIXED));
        end
        if (mode == MODE_ZERO) begin
            // XORI can only cancel a value that fits the sign-extended immediate
            if (model_acc[31:19] != '0 && model_acc[31:19] != '1) begin
                emit({OP_SHLI, 8'h00, 20'd16});
                emit({OP_SHLI, 8'h00, 20'd16});
            end
            emit({OP_XORI, 8'h00, model_acc[19:0]});
        end
        emit({OP_STORE, 8'h00, EXIT_ADDR[19:0]});
        for (int i = 0; i < prog.size(); i++) begin
            dut_i.ram_i.mem_i.mem[(BOOT / WORD_BYTES) + i] = prog[i];
        end
    endtask

    task automatic assert_reset();
        @(posedge clk);
        #2;
        rst_n        = 1'b0;
        fetch_enable = 1'b0;
        @(negedge clk);
        check_value("exit_valid_o", 32'd0, exit_valid);
        check_value("tests_passed_o", 32'd0, tests_passed);
        check_value("tests_failed_o", 32'd0, tests_failed);
        check_value("exit_value_o", 32'd0, exit_value);
    endtask

    // the core must not finish anything while fetch_enable_i is low
    task automatic start_program(input int mode, input int unsigned idle_cycles);
        assert_reset();
        build_program(mode);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (idle_cycles) begin
            @(negedge clk);
            check_value("exit_valid_o", 32'd0, exit_valid);
        end
        @(posedge clk);
        #2;
        fetch_enable = 1'b1;
    endtask

    task automatic wait_exit();
        int unsigned cycles;
        cycles = 0;
        @(negedge clk);
        while (exit_valid !== 1'b1) begin
            if (cycles >= EXIT_LIMIT) begin
                $display("the exit register was not written within %0d cycles", EXIT_LIMIT);
                $display("Some tests failed");
                $fatal(1, "program did not finish");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic run_program(input int mode, input int unsigned idle_cycles);
        start_program(mode, idle_cycles);
        wait_exit();
        check_value("exit_value_o", expected_exit, exit_value);
        check_value("tests_passed_o", expected_exit == 32'd0, tests_passed);
        check_value("tests_failed_o", expected_exit != 32'd0, tests_failed);
    endtask

    initial begin
        void'($urandom(32'h375e));
        rst_n        = 1'b0;
        fetch_enable = 1'b0;
        for (int t = 0; t < NUM_RANDOM; t++) begin
            run_program(t % 3, 0);
        end
        // the idle time is longer than any program would need to reach its exit store
        run_program(MODE_MIXED, $urandom_range(EXIT_LIMIT + MAX_IDLE, EXIT_LIMIT));
        // stop a run well before its exit store, then start a fresh one
        start_program(MODE_MIXED, 0);
        repeat ($urandom_range(16, 3)) @(posedge clk);
        assert_reset();
        run_program(MODE_ZERO, 0);
        if (dut_i.chk_i.assert_failures != 0) begin
            $display("%0d bus or exit assertions failed", dut_i.chk_i.assert_failures);
            $display("Some tests failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
hw/tiny_pkg.sv
hw/dp_ram.sv
hw/mm_ram.sv
hw/tiny_core.sv
hw/core_wrapper.sv
test/core_wrapper_chk.sv
test/tb_core_wrapper.sv

// File: Bender.yml
package:
  name: tiny_core_harness

# RTL first, package before its users
sources:
  - files:
      - hw/tiny_pkg.sv
      - hw/dp_ram.sv
      - hw/mm_ram.sv
      - hw/tiny_core.sv
      - hw/core_wrapper.sv

  # testbench and bound assertions, only for simulation
  - target: test
    files:
      - test/core_wrapper_chk.sv
      - test/tb_core_wrapper.sv
